//--- src/dma_dist_pkg.sv
////////////////////
// DMA distribution package
// Geometry, widths and slice kinds shared by the distribution blocks
////////////////////

`default_nettype none

package dma_dist_pkg;

  // Backend ports and region geometry
  localparam int unsigned NoMstPorts = 4;
  localparam int unsigned RegionWidth = 64;
  localparam int unsigned RegionBits = 6;
  localparam int unsigned StripeBits = 8;

  // Distributed memory window, end is exclusive
  localparam logic [31:0] DistStart = 32'h0000_0000;
  localparam logic [31:0] DistEnd = 32'h1000_0000;

  // Request field widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned LenWidth = 16;

  // Completions buffered per port
  localparam int unsigned TransFifoDepth = 4;

  // How one port takes part in a request
  typedef enum logic [2:0] {
    NONE,
    ONLY,
    FIRST,
    MIDDLE,
    LAST
  } slice_kind_e;

endpackage

`default_nettype wire

//--- src/dma_req_stage.sv
////////////////////
// Request register stage
// One full-throughput pipeline slot for a burst request
////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_req_stage (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Upstream side
  input  logic [dma_dist_pkg::AddrWidth-1:0]  src_i,
  input  logic [dma_dist_pkg::AddrWidth-1:0]  dst_i,
  input  logic [dma_dist_pkg::LenWidth-1:0]   len_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  // Downstream side
  output logic [dma_dist_pkg::AddrWidth-1:0]  src_o,
  output logic [dma_dist_pkg::AddrWidth-1:0]  dst_o,
  output logic [dma_dist_pkg::LenWidth-1:0]   len_o,
  output logic                                valid_o,
  input  logic                                ready_i
);

  logic valid_q;

  // Slot can take a new request when empty or when it drains this cycle
  assign ready_o = ~valid_q | ready_i;
  assign valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only follows accepted requests
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      src_o <= src_i;
      dst_o <= dst_i;
      len_o <= len_i;
    end
  end

endmodule

`default_nettype wire

//--- src/dma_dist_midend.sv
////////////////////
// DMA distribution midend
// Cuts one request into per-port slices, forks the handshake
// and joins the per-port completions into one pulse
////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_dist_midend (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  // Inbound request
  input  logic [dma_dist_pkg::AddrWidth-1:0]                            src_i,
  input  logic [dma_dist_pkg::AddrWidth-1:0]                            dst_i,
  input  logic [dma_dist_pkg::LenWidth-1:0]                             len_i,
  input  logic                                                          valid_i,
  output logic                                                          ready_o,
  // Per-port slices
  output logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] src_o,
  output logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] dst_o,
  output logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::LenWidth-1:0]  len_o,
  output logic [dma_dist_pkg::NoMstPorts-1:0]                           valid_o,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           ready_i,
  // Backend status
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           done_i,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           idle_i,
  output logic                                                          trans_complete_o,
  output logic                                                          backend_idle_o
);

  // One extra bit keeps the end offset from wrapping
  typedef logic [dma_dist_pkg::LenWidth:0] off_t;
  typedef logic [dma_dist_pkg::AddrWidth-1:0] addr_t;
  typedef logic [dma_dist_pkg::LenWidth-1:0] len_t;
  typedef logic [$clog2(dma_dist_pkg::TransFifoDepth):0] cnt_t;

  logic dist_is_src;
  addr_t dist_addr;
  off_t start_off;
  off_t end_off;

  logic fifo_ready;
  logic trans_complete_q;
  logic [dma_dist_pkg::NoMstPorts-1:0] fifo_full;
  logic [dma_dist_pkg::NoMstPorts-1:0] avail;
  logic [dma_dist_pkg::NoMstPorts-1:0] none_mask;
  logic [dma_dist_pkg::NoMstPorts-1:0] fork_valid;
  logic [dma_dist_pkg::NoMstPorts-1:0] port_ready;
  logic [dma_dist_pkg::NoMstPorts-1:0] branch_done;
  logic [dma_dist_pkg::NoMstPorts-1:0] tie_off;
  logic [dma_dist_pkg::NoMstPorts-1:0] taken_q;
  logic [dma_dist_pkg::NoMstPorts-1:0] idle_q;

  // The side inside the distributed window decides the slicing
  assign dist_is_src = (src_i >= dma_dist_pkg::DistStart) && (src_i < dma_dist_pkg::DistEnd);
  assign dist_addr = dist_is_src ? src_i : dst_i;
  assign start_off = off_t'(dist_addr[dma_dist_pkg::StripeBits-1:0]);
  assign end_off = start_off + off_t'(len_i);

  // Any full queue holds back new requests
  assign fifo_ready = ~|fifo_full;
  assign ready_o = fifo_ready & (&branch_done);

  for (genvar i = 0; i < dma_dist_pkg::NoMstPorts; i++) begin : gen_port
    off_t region_lo;
    off_t region_hi;
    off_t shift;
    cnt_t cnt_q;
    dma_dist_pkg::slice_kind_e kind;

    assign region_lo = off_t'(i * dma_dist_pkg::RegionWidth);
    assign region_hi = off_t'((i + 1) * dma_dist_pkg::RegionWidth);
    // Distance from the request start to this region's base
    assign shift = region_lo - start_off;

    always_comb begin
      if ((start_off >= region_hi) || (end_off <= region_lo)) begin
        kind = dma_dist_pkg::NONE;
      end else if (start_off >= region_lo) begin
        kind = (end_off <= region_hi) ? dma_dist_pkg::ONLY : dma_dist_pkg::FIRST;
      end else if (end_off >= region_hi) begin
        kind = dma_dist_pkg::MIDDLE;
      end else begin
        kind = dma_dist_pkg::LAST;
      end
    end

    always_comb begin
      src_o[i] = src_i;
      dst_o[i] = dst_i;
      len_o[i] = len_i;
      unique case (kind)
        dma_dist_pkg::NONE: begin
          src_o[i] = '0;
          dst_o[i] = '0;
          len_o[i] = '0;
        end
        dma_dist_pkg::FIRST: begin
          // Rest of the region the start falls in
          len_o[i] = len_t'(dma_dist_pkg::RegionWidth)
                   - len_t'(start_off[dma_dist_pkg::RegionBits-1:0]);
        end
        dma_dist_pkg::MIDDLE: begin
          src_o[i] = src_i + addr_t'(shift);
          dst_o[i] = dst_i + addr_t'(shift);
          len_o[i] = len_t'(dma_dist_pkg::RegionWidth);
        end
        dma_dist_pkg::LAST: begin
          src_o[i] = src_i + addr_t'(shift);
          dst_o[i] = dst_i + addr_t'(shift);
          len_o[i] = len_t'(end_off[dma_dist_pkg::RegionBits-1:0]);
        end
        default: begin
          // ONLY keeps the request as it is
          len_o[i] = len_i;
        end
      endcase
    end

    // Fork branch, NONE ports complete their own handshake
    assign none_mask[i] = (kind == dma_dist_pkg::NONE);
    assign fork_valid[i] = valid_i & fifo_ready & ~taken_q[i];
    assign port_ready[i] = none_mask[i] | ready_i[i];
    assign valid_o[i] = fork_valid[i] & ~none_mask[i];
    assign branch_done[i] = taken_q[i] | (fork_valid[i] & port_ready[i]);
    assign tie_off[i] = fork_valid[i] & none_mask[i];

    // Completion queue, entries carry no data so a counter is enough
    // A backend done and a tie-off may land in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + cnt_t'(done_i[i]) + cnt_t'(tie_off[i]) - cnt_t'(trans_complete_q);
      end
    end

    assign fifo_full[i] = (cnt_q >= cnt_t'(dma_dist_pkg::TransFifoDepth));
    // Still holds an entry after this cycle's pop
    assign avail[i] = (cnt_q > cnt_t'(trans_complete_q));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= '0;
      trans_complete_q <= 1'b0;
      idle_q <= '1;
    end else begin
      if (valid_i && ready_o) begin
        taken_q <= '0;
      end else begin
        taken_q <= taken_q | (fork_valid & port_ready);
      end
      trans_complete_q <= &avail;
      idle_q <= idle_i;
    end
  end

  assign trans_complete_o = trans_complete_q;
  assign backend_idle_o = &idle_q;

endmodule

`default_nettype wire

//--- src/dma_dist_top.sv
////////////////////
// DMA distribution top level
// Input stage, midend and one output stage per backend port
////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_dist_top (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  // Inbound request
  input  logic [dma_dist_pkg::AddrWidth-1:0]                            req_src_i,
  input  logic [dma_dist_pkg::AddrWidth-1:0]                            req_dst_i,
  input  logic [dma_dist_pkg::LenWidth-1:0]                             req_len_i,
  input  logic                                                          req_valid_i,
  output logic                                                          req_ready_o,
  // Slices towards the backends
  output logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] port_src_o,
  output logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] port_dst_o,
  output logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::LenWidth-1:0]  port_len_o,
  output logic [dma_dist_pkg::NoMstPorts-1:0]                           port_valid_o,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           port_ready_i,
  // Backend status
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           port_done_i,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           port_idle_i,
  output logic                                                          trans_complete_o,
  output logic                                                          backend_idle_o
);

  logic [dma_dist_pkg::AddrWidth-1:0] in_src;
  logic [dma_dist_pkg::AddrWidth-1:0] in_dst;
  logic [dma_dist_pkg::LenWidth-1:0] in_len;
  logic in_valid;
  logic in_ready;

  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] mid_src;
  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] mid_dst;
  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::LenWidth-1:0] mid_len;
  logic [dma_dist_pkg::NoMstPorts-1:0] mid_valid;
  logic [dma_dist_pkg::NoMstPorts-1:0] mid_ready;

  dma_req_stage i_in_stage (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .src_i   (req_src_i),
    .dst_i   (req_dst_i),
    .len_i   (req_len_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .src_o   (in_src),
    .dst_o   (in_dst),
    .len_o   (in_len),
    .valid_o (in_valid),
    .ready_i (in_ready)
  );

  dma_dist_midend i_midend (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .src_i            (in_src),
    .dst_i            (in_dst),
    .len_i            (in_len),
    .valid_i          (in_valid),
    .ready_o          (in_ready),
    .src_o            (mid_src),
    .dst_o            (mid_dst),
    .len_o            (mid_len),
    .valid_o          (mid_valid),
    .ready_i          (mid_ready),
    .done_i           (port_done_i),
    .idle_i           (port_idle_i),
    .trans_complete_o (trans_complete_o),
    .backend_idle_o   (backend_idle_o)
  );

  // Output register per backend port
  for (genvar i = 0; i < dma_dist_pkg::NoMstPorts; i++) begin : gen_out_stage
    dma_req_stage i_out_stage (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .src_i   (mid_src[i]),
      .dst_i   (mid_dst[i]),
      .len_i   (mid_len[i]),
      .valid_i (mid_valid[i]),
      .ready_o (mid_ready[i]),
      .src_o   (port_src_o[i]),
      .dst_o   (port_dst_o[i]),
      .len_o   (port_len_o[i]),
      .valid_o (port_valid_o[i]),
      .ready_i (port_ready_i[i])
    );
  end

endmodule

`default_nettype wire

//--- verification/dma_dist_properties.sv
////////////////////
// DMA distribution properties
// Handshake, reset and completion rules on the top level
////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_dist_properties (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  input  logic                                                          req_valid_i,
  input  logic                                                          req_ready_o,
  input  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] port_src_o,
  input  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] port_dst_o,
  input  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::LenWidth-1:0]  port_len_o,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           port_valid_o,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           port_ready_i,
  input  logic                                                          trans_complete_o,
  input  logic                                                          backend_idle_o
);

  int fail_count = 0;
  logic seen_req;

  // Set by the first accepted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_req <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      seen_req <= 1'b1;
    end
  end

  for (genvar i = 0; i < dma_dist_pkg::NoMstPorts; i++) begin : gen_port
    stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      port_valid_o[i] && !port_ready_i[i] |=> port_valid_o[i] && $stable(port_src_o[i])
        && $stable(port_dst_o[i]) && $stable(port_len_o[i]))
      else begin
        $error("Port %0d slice changed while stalled", i);
        fail_count++;
      end
  end

  complete_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_complete_o |-> seen_req)
    else begin
      $error("Completion pulse without any accepted request");
      fail_count++;
    end

  idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> backend_idle_o)
    else begin
      $error("backend_idle_o low right after reset");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (port_valid_o == '0) && !trans_complete_o)
    else begin
      $error("Valid or completion high during reset");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- verification/dma_dist_checker.sv
////////////////////
// DMA distribution checker
// Predicts per-port slices of every accepted request and
// compares them with the slices handed to the backends
////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_dist_checker (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  input  logic [dma_dist_pkg::AddrWidth-1:0]                            req_src_i,
  input  logic [dma_dist_pkg::AddrWidth-1:0]                            req_dst_i,
  input  logic [dma_dist_pkg::LenWidth-1:0]                             req_len_i,
  input  logic                                                          req_valid_i,
  input  logic                                                          req_ready_i,
  input  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] port_src_i,
  input  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::AddrWidth-1:0] port_dst_i,
  input  logic [dma_dist_pkg::NoMstPorts-1:0][dma_dist_pkg::LenWidth-1:0]  port_len_i,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           port_valid_i,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           port_ready_i,
  input  logic [dma_dist_pkg::NoMstPorts-1:0]                           port_idle_i,
  input  logic                                                          trans_complete_i,
  input  logic                                                          backend_idle_i
);

  localparam int NP = int'(dma_dist_pkg::NoMstPorts);
  localparam int QDepth = 256;

  // Expected slice per entry is {src, dst, len}
  logic [79:0] exp_mem [NP][QDepth];
  int wr_idx [NP];
  int rd_idx [NP];
  logic [NP-1:0] seen_mask = '0;
  logic idle_prev = 1'b1;
  logic busy_seen = 1'b0;
  int errors = 0;
  int requests = 0;
  int completions = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int err_base = 0;

  task automatic compare_field(input string sig, input int p, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("[FAIL] %0d ns %s[%0d] expected %h actual %h", $time, sig, p, exp_v, act_v);
      errors++;
    end
  endtask

  // Each port gets the part of the span that overlaps its region
  task automatic predict_slices(input logic [31:0] s, input logic [31:0] d,
                                input logic [15:0] l);
    logic [31:0] daddr;
    int start_off;
    int end_off;
    int lo;
    int hi;
    int shift;
    int stop;
    daddr = (s >= dma_dist_pkg::DistStart && s < dma_dist_pkg::DistEnd) ? s : d;
    start_off = int'(daddr[dma_dist_pkg::StripeBits-1:0]);
    end_off = start_off + int'(l);
    for (int p = 0; p < NP; p++) begin
      lo = p * int'(dma_dist_pkg::RegionWidth);
      hi = lo + int'(dma_dist_pkg::RegionWidth);
      if (start_off < hi && end_off > lo) begin
        shift = (start_off >= lo) ? 0 : lo - start_off;
        stop = (end_off < hi) ? end_off : hi;
        exp_mem[p][wr_idx[p] % QDepth] = {s + 32'(shift), d + 32'(shift),
                                          16'(stop - start_off - shift)};
        wr_idx[p]++;
      end
    end
  endtask

  task automatic check_slice(input int p);
    logic [79:0] exp_e;
    seen_mask[p] = 1'b1;
    if (rd_idx[p] == wr_idx[p]) begin
      $display("Port %0d issued a slice no request accounts for at %0d ns", p, $time);
      errors++;
    end else begin
      exp_e = exp_mem[p][rd_idx[p] % QDepth];
      rd_idx[p]++;
      compare_field("port_src_o", p, exp_e[79:48], port_src_i[p]);
      compare_field("port_dst_o", p, exp_e[47:16], port_dst_i[p]);
      compare_field("port_len_o", p, {16'h0, exp_e[15:0]}, {16'h0, port_len_i[p]});
    end
  endtask

  // Between edges every signal is settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (req_valid_i && req_ready_i) begin
        predict_slices(req_src_i, req_dst_i, req_len_i);
        requests++;
      end
      if (trans_complete_i) begin
        completions++;
      end
      // Idle flag lags the backend idle inputs by one cycle
      if (backend_idle_i !== idle_prev) begin
        $display("[FAIL] %0d ns backend_idle_o expected %b actual %b",
                 $time, idle_prev, backend_idle_i);
        errors++;
      end
      idle_prev = &port_idle_i;
      if (!backend_idle_i) begin
        busy_seen = 1'b1;
      end
      for (int p = 0; p < NP; p++) begin
        if (port_valid_i[p] && port_ready_i[p]) begin
          check_slice(p);
        end
      end
    end
  end

  task automatic end_test(input string name, input int extra, input logic [NP-1:0] exp_mask);
    int fails;
    for (int p = 0; p < NP; p++) begin
      if (rd_idx[p] != wr_idx[p]) begin
        $display("Port %0d never delivered %0d expected slices", p, wr_idx[p] - rd_idx[p]);
        errors++;
        rd_idx[p] = wr_idx[p];
      end
    end
    if (completions != requests) begin
      $display("Saw %0d completion pulses for %0d accepted requests", completions, requests);
      errors++;
    end
    if (seen_mask !== exp_mask) begin
      $display("[FAIL] %0d ns port_valid_o mask expected %b actual %b",
               $time, exp_mask, seen_mask);
      errors++;
    end
    if (!busy_seen) begin
      $display("backend_idle_o never went low while backends were busy");
      errors++;
    end
    errors += extra;
    fails = errors - err_base;
    err_base = errors;
    tests_run++;
    if (fails != 0) begin
      tests_failed++;
    end
    $display("Test %s %0d errors", name, fails);
    seen_mask = '0;
    busy_seen = 1'b0;
  endtask

  task automatic print_summary();
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
  endtask

endmodule

`default_nettype wire

//--- verification/tb_dma_dist.sv
////////////////////
// DMA distribution testbench
// Table-driven requests, backend models and the final verdict
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_dma_dist;

  localparam int NP = int'(dma_dist_pkg::NoMstPorts);
  localparam int NumTests = 6;
  localparam int WaitLimit = 400;
  localparam logic [31:0] Stride = 32'h0000_0110;

  typedef struct packed {
    logic [31:0]   src;
    logic [31:0]   dst;
    logic [15:0]   len;
    logic [7:0]    reps;
    logic          bp;
    logic [NP-1:0] mask;
  } row_t;

  // src, dst, length, requests, back-pressure, ports expected to take part
  row_t tbl [NumTests] = '{
    '{32'h0000_2048, 32'h9000_0000, 16'd16,  8'd1,  1'b0, 4'b0010},
    '{32'h0000_1020, 32'h8000_0000, 16'd120, 8'd1,  1'b0, 4'b0111},
    '{32'h2000_0040, 32'h0000_0030, 16'd150, 8'd1,  1'b0, 4'b1111},
    '{32'h0000_4000, 32'h8800_0000, 16'd64,  8'd10, 1'b0, 4'b1111},
    '{32'h0000_5008, 32'hA000_0000, 16'd60,  8'd12, 1'b1, 4'b1111},
    '{32'h0000_3000, 32'h8000_1000, 16'd256, 8'd1,  1'b1, 4'b1111}
  };
  string tbl_name [NumTests] = '{"single_region", "three_regions", "dst_sliced",
                                 "burst_ten", "back_pressure", "backend_idle"};

  logic clk_i = 1'b0;
  logic rst_ni;
  logic [31:0] req_src_i;
  logic [31:0] req_dst_i;
  logic [15:0] req_len_i;
  logic req_valid_i;
  logic req_ready_o;
  logic [NP-1:0][31:0] port_src_o;
  logic [NP-1:0][31:0] port_dst_o;
  logic [NP-1:0][15:0] port_len_o;
  logic [NP-1:0] port_valid_o;
  logic [NP-1:0] port_ready_i;
  logic [NP-1:0] port_done_i;
  logic [NP-1:0] port_idle_i;
  logic trans_complete_o;
  logic backend_idle_o;

  logic bp_en = 1'b0;
  logic [NP-1:0] took = '0;
  int busy_cnt [NP];
  int timeouts = 0;

  always #2 clk_i = ~clk_i;

  dma_dist_top dut0 (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_src_i(req_src_i), .req_dst_i(req_dst_i), .req_len_i(req_len_i),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .port_src_o(port_src_o), .port_dst_o(port_dst_o), .port_len_o(port_len_o),
    .port_valid_o(port_valid_o), .port_ready_i(port_ready_i),
    .port_done_i(port_done_i), .port_idle_i(port_idle_i),
    .trans_complete_o(trans_complete_o), .backend_idle_o(backend_idle_o)
  );

  dma_dist_checker chk0 (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_src_i(req_src_i), .req_dst_i(req_dst_i), .req_len_i(req_len_i),
    .req_valid_i(req_valid_i), .req_ready_i(req_ready_o),
    .port_src_i(port_src_o), .port_dst_i(port_dst_o), .port_len_i(port_len_o),
    .port_valid_i(port_valid_o), .port_ready_i(port_ready_i), .port_idle_i(port_idle_i),
    .trans_complete_i(trans_complete_o), .backend_idle_i(backend_idle_o)
  );

  bind dma_dist_top dma_dist_properties props0 (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .port_src_o(port_src_o), .port_dst_o(port_dst_o), .port_len_o(port_len_o),
    .port_valid_o(port_valid_o), .port_ready_i(port_ready_i),
    .trans_complete_o(trans_complete_o), .backend_idle_o(backend_idle_o)
  );

  // Backend models take one slice at a time and finish it 1 to 5 cycles later
  always @(negedge clk_i) took = port_valid_o & port_ready_i;

  always @(posedge clk_i) begin
    #1;
    for (int p = 0; p < NP; p++) begin
      port_done_i[p] = 1'b0;
      if (busy_cnt[p] > 0) begin
        busy_cnt[p]--;
        port_done_i[p] = (busy_cnt[p] == 0);
      end else if (took[p]) begin
        busy_cnt[p] = 1 + int'($urandom % 5);
      end
      port_idle_i[p] = (busy_cnt[p] == 0);
      port_ready_i[p] = (busy_cnt[p] == 0) && (!bp_en || ($urandom % 2 == 0));
    end
  end

  task automatic send_req(input logic [31:0] s, input logic [31:0] d, input logic [15:0] l);
    int cycles;
    req_src_i = s;
    req_dst_i = d;
    req_len_i = l;
    req_valid_i = 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!req_ready_o && cycles < WaitLimit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!req_ready_o) begin
      $display("Timeout: request at src %h was never accepted", s);
      timeouts++;
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic drain_test();
    int cycles;
    cycles = 0;
    while ((chk0.completions != chk0.requests || !backend_idle_o) && cycles < WaitLimit) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (chk0.completions != chk0.requests || !backend_idle_o) begin
      $display("Timeout: completions or backend idle did not arrive");
      timeouts++;
    end
  endtask

  initial begin
    void'($urandom(32'h80f869a4));
    req_src_i = '0;
    req_dst_i = '0;
    req_len_i = '0;
    req_valid_i = 1'b0;
    port_ready_i = '1;
    port_done_i = '0;
    port_idle_i = '1;
    rst_ni = 1'b1;
    #1 rst_ni = 1'b0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    for (int t = 0; t < NumTests; t++) begin
      bp_en = tbl[t].bp;
      for (int k = 0; k < int'(tbl[t].reps); k++) begin
        send_req(tbl[t].src + Stride * 32'(k), tbl[t].dst + Stride * 32'(k), tbl[t].len);
      end
      drain_test();
      chk0.end_test(tbl_name[t], timeouts, tbl[t].mask);
      timeouts = 0;
    end
    chk0.print_summary();
    if (chk0.errors == 0 && dut0.props0.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
src/dma_dist_pkg.sv
src/dma_req_stage.sv
src/dma_dist_midend.sv
src/dma_dist_top.sv
verification/dma_dist_properties.sv
verification/dma_dist_checker.sv
verification/tb_dma_dist.sv

//--- run_verilator.sh
#!/bin/sh
# Builds the DMA distribution testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module tb_dma_dist --Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx '\*\*\* TEST PASSED \*\*\*'
